// ==== cart_pkg.sv ====
package cart_pkg;

  ////////////////////////////////////////////////////////////
  // Mapper codes as set by the MCU
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    map_hirom      = 3'b000,
    map_lorom      = 3'b001,
    map_exhirom    = 3'b010,
    map_bsx        = 3'b011,
    map_exlorom    = 3'b100,
    map_interleave = 3'b110,
    map_menu       = 3'b111
  } mapper_t;

  // Bit positions in the feature word
  localparam int feat_st0010 = 1;
  localparam int feat_msu1   = 3;
  localparam int feat_213f   = 4;
  localparam int feat_2100   = 6;

  // Bus widths
  localparam int addr_w = 24;
  localparam int pa_w   = 8;
  localparam int data_w = 8;
  localparam int feat_w = 16;

  ////////////////////////////////////////////////////////////
  // PSRAM layout
  ////////////////////////////////////////////////////////////
  localparam logic [addr_w-1:0] saveram_base  = 24'hE00000;
  localparam logic [addr_w-1:0] menu_rom_base = 24'hC00000;

  // LoROM save RAM shrinks to the low half of the bank from 32 Mbit up
  localparam int rom_32m_bit = 21;

  // Save RAM window start for the interleaved layout
  localparam logic [14:0] il_sram_off = 15'h6000;

  // Tag of {A22, A15:A9} for the $2A00-$2BFF command window
  localparam logic [7:0] snescmd_page = 8'h15;

  // Hook addresses
  localparam logic [addr_w-1:0] nmicmd_addr        = 24'h002BF2;
  localparam logic [addr_w-1:0] return_vector_addr = 24'h002A6C;
  localparam logic [addr_w-1:0] branch1_addr       = 24'h002A1F;
  localparam logic [addr_w-1:0] branch2_addr       = 24'h002A59;
  localparam logic [addr_w-1:0] branch3_addr       = 24'h002A5E;

  // MSU1 register block
  localparam logic [15:0] msu_base = 16'h2000;
  localparam int          msu_size = 8;

  // B-bus register addresses
  localparam logic [pa_w-1:0] r213f_pa = 8'h3F;
  localparam logic [pa_w-1:0] r2100_pa = 8'h00;

endpackage

// ==== snes_bus_if.sv ====
interface snes_bus_if;

  // Console bus after registering
  logic [cart_pkg::addr_w-1:0] addr;
  logic [cart_pkg::pa_w-1:0]   pa;
  logic [cart_pkg::data_w-1:0] data;
  logic                        romsel_n;

  // One cycle per access, never both
  logic                        rd_pulse;
  logic                        wr_pulse;

  // Synchroniser side
  modport src (
    output addr, pa, data, romsel_n, rd_pulse, wr_pulse
  );

  // Access consumers
  modport dst (
    input data, rd_pulse, wr_pulse
  );

  // Combinational decoder, PA needed for B-bus hits
  modport map (
    input addr, pa, romsel_n
  );

endinterface

// ==== addr_map_if.sv ====
interface addr_map_if;

  // PSRAM address and region flags
  logic [cart_pkg::addr_w-1:0] rom_addr;
  logic                        rom_hit;
  logic                        is_saveram;
  logic                        is_writable;

  // Peripheral windows
  logic                        msu_enable;
  logic                        r213f_enable;
  logic                        r2100_hit;

  // Hook addresses
  logic                        snescmd_enable;
  logic                        nmicmd_enable;
  logic                        return_vector_enable;
  logic                        branch1_enable;
  logic                        branch2_enable;
  logic                        branch3_enable;

  modport src (
    output rom_addr, rom_hit, is_saveram, is_writable,
           msu_enable, r213f_enable, r2100_hit,
           snescmd_enable, nmicmd_enable, return_vector_enable,
           branch1_enable, branch2_enable, branch3_enable
  );

  modport dst (
    input rom_addr, rom_hit, is_saveram, is_writable,
          msu_enable, r213f_enable, r2100_hit,
          snescmd_enable, nmicmd_enable, return_vector_enable,
          branch1_enable, branch2_enable, branch3_enable
  );

endinterface

// ==== snes_bus_sync.sv ====
module snes_bus_sync (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic [cart_pkg::addr_w-1:0] snes_addr,
  input  logic [cart_pkg::pa_w-1:0]   snes_pa,
  input  logic [cart_pkg::data_w-1:0] snes_data,
  input  logic                        snes_romsel_n,
  input  logic                        snes_rd_n,
  input  logic                        snes_wr_n,
  snes_bus_if.src                     bus
);

  // Bit 0 is RD, bit 1 is WR
  logic [1:0] strobe_s1;
  logic [1:0] strobe_s2;
  logic [1:0] strobe_prev;
  logic [1:0] fall;
  logic [1:0] pulse_q;

  // Address and data, one cycle late
  always_ff @(posedge CLK) begin
    bus.addr     <= snes_addr;
    bus.pa       <= snes_pa;
    bus.data     <= snes_data;
    bus.romsel_n <= snes_romsel_n;
  end

  ////////////////////////////////////////////////////////////
  // Strobe synchronisers and edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (reset) begin
      // Idle strobe is high
      strobe_s1   <= 2'b11;
      strobe_s2   <= 2'b11;
      strobe_prev <= 2'b11;
    end else begin
      strobe_s1   <= {snes_wr_n, snes_rd_n};
      strobe_s2   <= strobe_s1;
      strobe_prev <= strobe_s2;
    end
  end

  // High to low after the second flop
  assign fall = strobe_prev & ~strobe_s2;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pulse_q <= 2'b00;
    end else begin
      // Write wins if both ever fall together
      pulse_q[0] <= fall[0] & ~fall[1];
      pulse_q[1] <= fall[1];
    end
  end

  assign bus.rd_pulse = pulse_q[0];
  assign bus.wr_pulse = pulse_q[1];

endmodule

// ==== address_map.sv ====
module address_map (
  input  cart_pkg::mapper_t           mapper,
  input  logic [cart_pkg::feat_w-1:0] featurebits,
  input  logic [cart_pkg::addr_w-1:0] saveram_mask,
  input  logic [cart_pkg::addr_w-1:0] rom_mask,
  snes_bus_if.map                     bus,
  addr_map_if.src                     map
);

  logic [cart_pkg::addr_w-1:0] a;
  logic                        st0010_win;
  logic                        mapper_win;
  logic                        is_saveram;
  logic [cart_pkg::addr_w-1:0] sram_off;
  logic [cart_pkg::addr_w-1:0] rom_raw;
  logic                        rom_masked;
  logic [14:0]                 il_off;
  logic [15:0]                 msu_off;

  assign a = bus.addr;

  ////////////////////////////////////////////////////////////
  // Save RAM windows
  ////////////////////////////////////////////////////////////

  // ST0010 window in banks D0-DF at offset 0800-0FFF
  assign st0010_win = (a[23:20] == 4'hD) & (a[15:11] == 5'b00001);

  always_comb begin
    case (mapper)
      // Banks 20-3F at offset 6000-7FFF
      cart_pkg::map_hirom,
      cart_pkg::map_exhirom,
      cart_pkg::map_interleave:
        mapper_win = (a[23:21] == 3'b001) & (a[15:13] == 3'b011);
      // Banks 70-77 at offset 6000-7FFF
      cart_pkg::map_exlorom:
        mapper_win = (a[23:19] == 5'b01110) & (a[15:13] == 3'b011);
      // Banks 70-7F with the upper half dropped for big ROMs
      cart_pkg::map_lorom:
        mapper_win = (a[23:20] == 4'h7) & (~a[15] | ~rom_mask[cart_pkg::rom_32m_bit]);
      // Banks 10-17 at offset 5000-5FFF
      cart_pkg::map_bsx:
        mapper_win = (a[23:19] == 5'b00010) & (a[15:12] == 4'h5);
      // Whole banks F0-FF
      cart_pkg::map_menu:
        mapper_win = (a[23:20] == 4'hF);
      default:
        mapper_win = 1'b0;
    endcase
  end

  // Mask bit 0 says save RAM is present at all
  assign is_saveram = saveram_mask[0] & (featurebits[cart_pkg::feat_st0010] ?
                                         st0010_win : mapper_win);

  ////////////////////////////////////////////////////////////
  // PSRAM address per mapper
  ////////////////////////////////////////////////////////////
  assign il_off = a[14:0] - cart_pkg::il_sram_off;

  always_comb begin
    rom_masked = 1'b1;
    case (mapper)
      cart_pkg::map_hirom: begin
        sram_off = {6'd0, a[20:16], a[12:0]};
        rom_raw  = {1'b0, a[22:0]};
      end
      cart_pkg::map_lorom: begin
        // 32K pages with A15 dropped
        sram_off = {4'd0, a[20:16], a[14:0]};
        rom_raw  = {1'b0, ~a[23], a[22:16], a[14:0]};
      end
      cart_pkg::map_exhirom,
      cart_pkg::map_exlorom: begin
        // Banks 80-FF come first in the image
        sram_off = {7'd0, a[19:16], a[12:0]};
        rom_raw  = {1'b0, ~a[23], a[21:0]};
      end
      cart_pkg::map_bsx: begin
        sram_off = {9'd0, a[18:16], a[11:0]};
        rom_raw  = {1'b0, ~a[23], a[22:16], a[14:0]};
      end
      cart_pkg::map_interleave: begin
        // Upper halves linear and lower halves above 64 Mbit
        sram_off   = {9'd0, il_off};
        rom_raw    = a[15] ? {1'b0, a[23:16], a[14:0]}
                           : {2'b10, a[23], a[21:16], a[14:0]};
        rom_masked = 1'b0;
      end
      cart_pkg::map_menu: begin
        sram_off = a;
        rom_raw  = {1'b0, a[22:0]};
      end
      default: begin
        sram_off = '0;
        rom_raw  = '0;
      end
    endcase
  end

  always_comb begin
    if (mapper == cart_pkg::map_menu) begin
      // Menu save RAM is mapped 1:1 and menu ROM sits high
      map.rom_addr = is_saveram ? sram_off
                                : ((rom_raw & rom_mask) + cart_pkg::menu_rom_base);
    end else if (is_saveram) begin
      map.rom_addr = cart_pkg::saveram_base + (sram_off & saveram_mask);
    end else begin
      map.rom_addr = rom_masked ? (rom_raw & rom_mask) : rom_raw;
    end
  end

  assign map.is_saveram  = is_saveram;
  assign map.is_writable = is_saveram;
  assign map.rom_hit     = ~bus.romsel_n | is_saveram;

  ////////////////////////////////////////////////////////////
  // Peripheral and hook decode
  ////////////////////////////////////////////////////////////

  // MSU1 regs in banks 00-3F and 80-BF
  assign msu_off        = a[15:0] - cart_pkg::msu_base;
  assign map.msu_enable = featurebits[cart_pkg::feat_msu1] & ~a[22] &
                          (msu_off < 16'(cart_pkg::msu_size));

  assign map.r213f_enable = featurebits[cart_pkg::feat_213f] & (bus.pa == cart_pkg::r213f_pa);
  assign map.r2100_hit    = featurebits[cart_pkg::feat_2100] & (bus.pa == cart_pkg::r2100_pa);

  assign map.snescmd_enable       = ({a[22], a[15:9]} == cart_pkg::snescmd_page);
  assign map.nmicmd_enable        = (a == cart_pkg::nmicmd_addr);
  assign map.return_vector_enable = (a == cart_pkg::return_vector_addr);
  assign map.branch1_enable       = (a == cart_pkg::branch1_addr);
  assign map.branch2_enable       = (a == cart_pkg::branch2_addr);
  assign map.branch3_enable       = (a == cart_pkg::branch3_addr);

endmodule

// ==== mem_request.sv ====
module mem_request (
  input  logic                        CLK,
  input  logic                        reset,
  snes_bus_if.dst                     bus,
  addr_map_if.dst                     map,
  output logic [cart_pkg::addr_w-1:0] psram_addr,
  output logic                        psram_rd,
  output logic                        psram_wr,
  output logic                        psram_saveram
);

  logic rd_req;
  logic wr_req;

  // Reads need ROMSEL or a writable area
  assign rd_req = bus.rd_pulse & map.rom_hit;

  // ROM writes go nowhere
  assign wr_req = bus.wr_pulse & map.is_writable;

  ////////////////////////////////////////////////////////////
  // Request strobes
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (reset) begin
      psram_rd <= 1'b0;
      psram_wr <= 1'b0;
    end else begin
      psram_rd <= rd_req;
      psram_wr <= wr_req;
    end
  end

  // Address held until the next request
  always_ff @(posedge CLK) begin
    if (rd_req | wr_req) begin
      psram_addr    <= map.rom_addr;
      psram_saveram <= map.is_saveram;
    end
  end

endmodule

// ==== hook_flags.sv ====
module hook_flags (
  input  logic                        CLK,
  input  logic                        reset,
  snes_bus_if.dst                     bus,
  addr_map_if.dst                     map,
  output logic                        msu_access,
  output logic                        r213f_read,
  output logic                        snescmd_access,
  output logic                        nmi_hook,
  output logic                        return_hook,
  output logic [2:0]                  branch_hook,
  output logic [cart_pkg::data_w-1:0] r2100_value
);

  logic access;

  // Either direction counts for the hooks
  assign access = bus.rd_pulse | bus.wr_pulse;

  ////////////////////////////////////////////////////////////
  // Hit pulses, one cycle after the access pulse
  ////////////////////////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (reset) begin
      msu_access     <= 1'b0;
      r213f_read     <= 1'b0;
      snescmd_access <= 1'b0;
      nmi_hook       <= 1'b0;
      return_hook    <= 1'b0;
      branch_hook    <= 3'b000;
    end else begin
      msu_access     <= access & map.msu_enable;
      // $213F only matters on reads
      r213f_read     <= bus.rd_pulse & map.r213f_enable;
      snescmd_access <= access & map.snescmd_enable;
      nmi_hook       <= access & map.nmicmd_enable;
      return_hook    <= access & map.return_vector_enable;
      // Bit n is branch n+1
      branch_hook    <= {3{access}} & {map.branch3_enable,
                                       map.branch2_enable,
                                       map.branch1_enable};
    end
  end

  // Last value written to INIDISP
  always_ff @(posedge CLK) begin
    if (reset) begin
      r2100_value <= '0;
    end else if (bus.wr_pulse & map.r2100_hit) begin
      r2100_value <= bus.data;
    end
  end

endmodule

// ==== cart_addr_top.sv ====
module cart_addr_top (
  input  logic                        CLK,
  input  logic                        reset,
  // Static configuration from the MCU
  input  cart_pkg::mapper_t           mapper,
  input  logic [cart_pkg::feat_w-1:0] featurebits,
  input  logic [cart_pkg::addr_w-1:0] saveram_mask,
  input  logic [cart_pkg::addr_w-1:0] rom_mask,
  // Console bus
  input  logic [cart_pkg::addr_w-1:0] snes_addr,
  input  logic [cart_pkg::pa_w-1:0]   snes_pa,
  input  logic [cart_pkg::data_w-1:0] snes_data,
  input  logic                        snes_romsel_n,
  input  logic                        snes_rd_n,
  input  logic                        snes_wr_n,
  // PSRAM request
  output logic [cart_pkg::addr_w-1:0] psram_addr,
  output logic                        psram_rd,
  output logic                        psram_wr,
  output logic                        psram_saveram,
  // Hooks and peripherals
  output logic                        msu_access,
  output logic                        r213f_read,
  output logic                        snescmd_access,
  output logic                        nmi_hook,
  output logic                        return_hook,
  output logic [2:0]                  branch_hook,
  output logic [cart_pkg::data_w-1:0] r2100_value
);

  snes_bus_if bus ();
  addr_map_if map ();

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////
  snes_bus_sync u_sync (
    .CLK(CLK), .reset(reset),
    .snes_addr(snes_addr), .snes_pa(snes_pa), .snes_data(snes_data),
    .snes_romsel_n(snes_romsel_n), .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n),
    .bus(bus.src)
  );

  address_map u_map (
    .mapper(mapper), .featurebits(featurebits),
    .saveram_mask(saveram_mask), .rom_mask(rom_mask),
    .bus(bus.map), .map(map.src)
  );

  // Execute
  mem_request u_req (
    .CLK(CLK), .reset(reset), .bus(bus.dst), .map(map.dst),
    .psram_addr(psram_addr), .psram_rd(psram_rd), .psram_wr(psram_wr),
    .psram_saveram(psram_saveram)
  );

  // Result
  hook_flags u_hooks (
    .CLK(CLK), .reset(reset), .bus(bus.dst), .map(map.dst),
    .msu_access(msu_access), .r213f_read(r213f_read), .snescmd_access(snescmd_access),
    .nmi_hook(nmi_hook), .return_hook(return_hook), .branch_hook(branch_hook),
    .r2100_value(r2100_value)
  );

endmodule

// ==== tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Save RAM window, by bank and offset ranges
////////////////////////////////////////////////////////////
function automatic logic ref_saveram(input cart_pkg::mapper_t m,
                                     input logic [cart_pkg::feat_w-1:0] feat,
                                     input logic [23:0] smask,
                                     input logic [23:0] rmask,
                                     input logic [23:0] a);
  logic [7:0]  bank;
  logic [15:0] off;
  logic        win;
  bank = a[23:16];
  off  = a[15:0];
  if (feat[cart_pkg::feat_st0010]) begin
    // ST0010 window overrides the mapper
    win = (bank >= 8'hD0) && (bank <= 8'hDF) && (off >= 16'h0800) && (off <= 16'h0FFF);
  end else begin
    case (m)
      cart_pkg::map_hirom, cart_pkg::map_exhirom, cart_pkg::map_interleave:
        win = (bank >= 8'h20) && (bank <= 8'h3F) && (off >= 16'h6000) && (off <= 16'h7FFF);
      cart_pkg::map_exlorom:
        win = (bank >= 8'h70) && (bank <= 8'h77) && (off >= 16'h6000) && (off <= 16'h7FFF);
      // 32 Mbit and up keeps only the low half
      cart_pkg::map_lorom:
        win = (bank >= 8'h70) && (bank <= 8'h7F) && (!rmask[21] || (off < 16'h8000));
      cart_pkg::map_bsx:
        win = (bank >= 8'h10) && (bank <= 8'h17) && (off >= 16'h5000) && (off <= 16'h5FFF);
      cart_pkg::map_menu:
        win = (bank >= 8'hF0);
      default:
        win = 1'b0;
    endcase
  end
  return smask[0] && win;
endfunction

////////////////////////////////////////////////////////////
// Expected PSRAM address
////////////////////////////////////////////////////////////
function automatic logic [23:0] ref_rom_addr(input cart_pkg::mapper_t m,
                                             input logic [cart_pkg::feat_w-1:0] feat,
                                             input logic [23:0] smask,
                                             input logic [23:0] rmask,
                                             input logic [23:0] a);
  logic [23:0] bank;
  logic [23:0] off;
  logic [23:0] soff;
  logic [23:0] raw;
  bank = {16'd0, a[23:16]};
  off  = {8'd0, a[15:0]};
  if (ref_saveram(m, feat, smask, rmask, a)) begin
    case (m)
      cart_pkg::map_hirom:   soff = (bank & 24'h1F) * 24'h2000 + (off & 24'h1FFF);
      cart_pkg::map_lorom:   soff = (bank & 24'h1F) * 24'h8000 + (off & 24'h7FFF);
      cart_pkg::map_exhirom,
      cart_pkg::map_exlorom: soff = (bank & 24'h0F) * 24'h2000 + (off & 24'h1FFF);
      cart_pkg::map_bsx:     soff = (bank & 24'h07) * 24'h1000 + (off & 24'h0FFF);
      // 15 bit offset from $6000, wraps
      cart_pkg::map_interleave: soff = ((off & 24'h7FFF) - 24'h6000) & 24'h7FFF;
      default:               soff = a;
    endcase
    if (m == cart_pkg::map_menu) begin
      return a;
    end
    return 24'hE00000 + (soff & smask);
  end
  case (m)
    // 32K pages, banks 80-FF first
    cart_pkg::map_lorom, cart_pkg::map_bsx:
      raw = (bank ^ 24'h80) * 24'h8000 + (off & 24'h7FFF);
    cart_pkg::map_exhirom, cart_pkg::map_exlorom:
      raw = (bank[7] ? 24'h000000 : 24'h400000) + (a & 24'h3FFFFF);
    cart_pkg::map_interleave: begin
      // Unmasked, low halves above 64 Mbit
      if (off[15]) begin
        return bank * 24'h8000 + (off & 24'h7FFF);
      end
      return 24'h800000 + (bank[7] ? 24'h200000 : 24'h000000)
             + (bank & 24'h3F) * 24'h8000 + (off & 24'h7FFF);
    end
    cart_pkg::map_menu:
      return ((a & 24'h7FFFFF) & rmask) + 24'hC00000;
    default:
      raw = a & 24'h7FFFFF;
  endcase
  return raw & rmask;
endfunction

// Hook vector {msu, 213f, snescmd, nmi, return, branch3..1}
function automatic logic [7:0] ref_hooks(input logic [23:0] a, input logic [7:0] pa,
                                         input logic [cart_pkg::feat_w-1:0] feat,
                                         input logic is_read);
  logic       msu;
  logic       r3f;
  logic       cmd;
  logic       nmi;
  logic       ret;
  logic [2:0] br;
  msu = feat[cart_pkg::feat_msu1] && !a[22] && (a[15:0] >= 16'h2000) && (a[15:0] < 16'h2008);
  r3f = feat[cart_pkg::feat_213f] && is_read && (pa == 8'h3F);
  cmd = !a[22] && (a[15:0] >= 16'h2A00) && (a[15:0] <= 16'h2BFF);
  nmi = (a == 24'h002BF2);
  ret = (a == 24'h002A6C);
  br  = {a == 24'h002A5E, a == 24'h002A59, a == 24'h002A1F};
  return {msu, r3f, cmd, nmi, ret, br};
endfunction

`endif

// ==== tb_cart_addr.sv ====
module tb_cart_addr;
  timeunit 1ns;
  timeprecision 1ps;

  logic                        CLK;
  logic                        reset;
  cart_pkg::mapper_t           mapper;
  logic [cart_pkg::feat_w-1:0] featurebits;
  logic [cart_pkg::addr_w-1:0] saveram_mask;
  logic [cart_pkg::addr_w-1:0] rom_mask;
  logic [cart_pkg::addr_w-1:0] snes_addr;
  logic [cart_pkg::pa_w-1:0]   snes_pa;
  logic [cart_pkg::data_w-1:0] snes_data;
  logic                        snes_romsel_n;
  logic                        snes_rd_n;
  logic                        snes_wr_n;
  logic [cart_pkg::addr_w-1:0] psram_addr;
  logic                        psram_rd;
  logic                        psram_wr;
  logic                        psram_saveram;
  logic                        msu_access;
  logic                        r213f_read;
  logic                        snescmd_access;
  logic                        nmi_hook;
  logic                        return_hook;
  logic [2:0]                  branch_hook;
  logic [cart_pkg::data_w-1:0] r2100_value;
  logic [7:0]                  hooks;

  // Expected results of the access in flight
  logic                        exp_rd;
  logic                        exp_wr;
  logic                        exp_sram;
  logic [cart_pkg::addr_w-1:0] exp_addr;
  logic [7:0]                  exp_hooks;
  logic [cart_pkg::data_w-1:0] exp_r2100;

  int          pulse_cnt = 0;
  int          mismatches = 0;
  int          failures = 0;
  logic [31:0] lfsr;

  // Mappers and a save RAM window base for each
  cart_pkg::mapper_t maps [7] = '{cart_pkg::map_hirom, cart_pkg::map_lorom,
                                  cart_pkg::map_exhirom, cart_pkg::map_bsx,
                                  cart_pkg::map_exlorom, cart_pkg::map_interleave,
                                  cart_pkg::map_menu};
  logic [23:0] win_base [7] = '{24'h206000, 24'h700000, 24'h206000, 24'h105000,
                                24'h706000, 24'h206000, 24'hF00000};
  // Hooks, window edges and near misses
  logic [23:0] hook_addrs [13] = '{24'h002BF2, 24'h002A6C, 24'h002A1F, 24'h002A59,
                                   24'h002A5E, 24'h002A00, 24'h002BFF, 24'h802A6C,
                                   24'h002BF3, 24'h002A60, 24'h0029FF, 24'h002C00,
                                   24'h402A6C};

  `include "tb_ref_model.svh"

  cart_addr_top uut (.*);

  assign hooks = {msu_access, r213f_read, snescmd_access, nmi_hook, return_hook, branch_hook};

  always #20 CLK = ~CLK;

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_addr(input logic [cart_pkg::addr_w-1:0] got, exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_hooks(input logic [7:0] got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: hooks are %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_byte(input logic [cart_pkg::data_w-1:0] got, exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Any output pulse is compared against the expectation
  always @(negedge CLK) begin
    if (!reset && ((psram_rd | psram_wr | (|hooks)) !== 1'b0)) begin
      pulse_cnt = pulse_cnt + 1;
      check_flag(psram_rd, exp_rd, "psram_rd");
      check_flag(psram_wr, exp_wr, "psram_wr");
      if (exp_rd || exp_wr) begin
        check_addr(psram_addr, exp_addr, "psram_addr");
        check_flag(psram_saveram, exp_sram, "psram_saveram");
      end
      check_hooks(hooks, exp_hooks);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Only while the bus is idle
  task automatic set_config(input cart_pkg::mapper_t m, input logic [15:0] f,
                            input logic [23:0] sm, input logic [23:0] rm);
    @(posedge CLK);
    mapper       <= m;
    featurebits  <= f;
    saveram_mask <= sm;
    rom_mask     <= rm;
    @(posedge CLK);
  endtask

  task automatic run_access(input logic [23:0] a, input logic [7:0] pa, input logic [7:0] d,
                            input logic rsel_n, input logic wr);
    int   cyc;
    int   i;
    int   start;
    logic want;
    exp_sram  = ref_saveram(mapper, featurebits, saveram_mask, rom_mask, a);
    exp_addr  = ref_rom_addr(mapper, featurebits, saveram_mask, rom_mask, a);
    exp_rd    = !wr && (!rsel_n || exp_sram);
    exp_wr    = wr && exp_sram;
    exp_hooks = ref_hooks(a, pa, featurebits, !wr);
    want      = exp_rd || exp_wr || (exp_hooks != 8'h00);
    start     = pulse_cnt;
    @(posedge CLK);
    snes_addr     <= a;
    snes_pa       <= pa;
    snes_data     <= d;
    snes_romsel_n <= rsel_n;
    if (wr) begin
      snes_wr_n <= 1'b0;
    end else begin
      snes_rd_n <= 1'b0;
    end
    // Strobe low for six cycles
    for (cyc = 0; cyc < 6; cyc++) begin
      @(posedge CLK);
    end
    snes_rd_n <= 1'b1;
    snes_wr_n <= 1'b1;
    // No pulse expected means the whole window runs out
    while (pulse_cnt == start && cyc < 20) begin
      @(posedge CLK);
      cyc++;
    end
    for (i = 0; i < 4; i++) begin
      @(posedge CLK);
    end
    if (want && pulse_cnt == start) begin
      failures++;
      $display("ERROR at %0t ns: no request seen before timeout, address %h", $time, a);
    end else if (pulse_cnt - start > 1) begin
      failures++;
      $display("ERROR at %0t ns: more than one pulse for one access, address %h", $time, a);
    end
    if (wr && featurebits[cart_pkg::feat_2100] && pa == 8'h00) begin
      exp_r2100 = d;
    end
    check_byte(r2100_value, exp_r2100, "r2100_value");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [23:0] a;
    logic [23:0] smask;
    int          i;
    int          j;
    CLK = 1'b0;
    reset = 1'b1;
    mapper = cart_pkg::map_hirom;
    featurebits = '0;
    saveram_mask = '0;
    rom_mask = '0;
    snes_addr = '0;
    snes_pa = '0;
    snes_data = '0;
    snes_romsel_n = 1'b1;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    exp_rd = 1'b0;
    exp_wr = 1'b0;
    exp_sram = 1'b0;
    exp_addr = '0;
    exp_hooks = '0;
    exp_r2100 = '0;
    lfsr = 32'hddf46a39;
    for (i = 0; i < 5; i++) begin
      @(posedge CLK);
    end
    reset <= 1'b0;

    // Idle bus after reset
    for (i = 0; i < 10; i++) begin
      @(posedge CLK);
    end
    if (pulse_cnt != 0) begin
      failures++;
      $display("ERROR at %0t ns: output pulse after reset without any strobe", $time);
    end
    check_byte(r2100_value, 8'h00, "r2100_value after reset");

    // Random ROM reads under random masks
    for (i = 0; i < 7; i++) begin
      take_bits(24, r);
      take_bits(24, r2);
      set_config(maps[i], '0, r2[23:0], r[23:0]);
      for (j = 0; j < 8; j++) begin
        take_bits(24, r);
        take_bits(8, r2);
        run_access(r[23:0], r2[7:0], 8'h00, 1'b0, 1'b0);
      end
    end

    // Save RAM windows, then the same address with save RAM off
    for (i = 0; i < 7; i++) begin
      take_bits(24, r);
      smask = r[23:0] | 24'h000001;
      set_config(maps[i], '0, smask, 24'h3FFFFF);
      take_bits(15, r2);
      a = win_base[i] + {5'd0, r2[14:12], 4'd0, r2[11:0]};
      take_bits(8, r);
      run_access(a, 8'hFF, 8'h00, 1'b1, 1'b0);
      run_access(a, 8'hFF, r[7:0], 1'b1, 1'b1);
      // ROM write is dropped
      run_access(24'hC18000, 8'hFF, r[7:0], 1'b0, 1'b1);
      set_config(maps[i], '0, smask & 24'hFFFFFE, 24'h3FFFFF);
      run_access(a, 8'hFF, 8'h00, 1'b0, 1'b0);
      run_access(a, 8'hFF, 8'h00, 1'b1, 1'b0);
      run_access(a, 8'hFF, r[7:0], 1'b1, 1'b1);
    end

    // ST0010 window
    set_config(cart_pkg::map_hirom, 16'h0002, 24'hFFFFFF, 24'h3FFFFF);
    take_bits(11, r);
    run_access(24'hD30800 + {13'd0, r[10:0]}, 8'hFF, 8'h00, 1'b1, 1'b0);
    run_access(24'hD30800 + {13'd0, r[10:0]}, 8'hFF, 8'h5A, 1'b1, 1'b1);
    run_access(24'h206000, 8'hFF, 8'h00, 1'b1, 1'b0);

    // Hook addresses and near misses
    set_config(cart_pkg::map_hirom, '0, '0, 24'h3FFFFF);
    for (i = 0; i < 13; i++) begin
      run_access(hook_addrs[i], 8'hFF, 8'h00, 1'b1, 1'b0);
    end
    run_access(24'h002BF2, 8'hFF, 8'h11, 1'b1, 1'b1);

    // MSU and $213F follow their feature bits
    run_access(24'h002000, 8'hFF, 8'h00, 1'b1, 1'b0);
    run_access(24'h00213F, 8'h3F, 8'h00, 1'b1, 1'b0);
    set_config(cart_pkg::map_hirom, 16'h0058, '0, 24'h3FFFFF);
    for (i = 0; i < 9; i++) begin
      run_access(24'h002000 + 24'(i), 8'hFF, 8'h00, 1'b1, 1'b0);
    end
    run_access(24'h00213F, 8'h3F, 8'h00, 1'b1, 1'b0);
    run_access(24'h00213F, 8'h3F, 8'h00, 1'b1, 1'b1);

    // $2100 latch, write then read
    take_bits(8, r);
    run_access(24'h002100, 8'h00, r[7:0], 1'b1, 1'b1);
    run_access(24'h002100, 8'h00, ~r[7:0], 1'b1, 1'b0);
    set_config(cart_pkg::map_hirom, 16'h0018, '0, 24'h3FFFFF);
    run_access(24'h002100, 8'h00, ~r[7:0], 1'b1, 1'b1);

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
cart_pkg.sv
snes_bus_if.sv
addr_map_if.sv
snes_bus_sync.sv
address_map.sv
mem_request.sv
hook_flags.sv
cart_addr_top.sv
tb_cart_addr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cart address decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_cart_addr -f sim.f -o tb_cart_addr_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_cart_addr_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0
